//--- src/gmii_rx_pkg.sv
// Types and constants of the 8-bit GMII receiver; the widths are fixed by 1G Ethernet
package gmii_rx_pkg;

    typedef logic [7:0]  gmii_byte_t;    // One octet on the GMII data bus
    typedef logic [31:0] crc_t;          // CRC-32 register value

    // One clock's view of the GMII receive pins
    typedef struct packed {
        gmii_byte_t data;
        logic       dv;
        logic       er;
    } gmii_sample_t;

    // One beat of the output stream, valid is carried beside it
    typedef struct packed {
        gmii_byte_t data;
        logic       last;
        logic       user;                // Set on the last beat of a damaged frame
    } rx_beat_t;

    typedef struct packed {
        logic start_packet;
        logic bad_frame;                 // Receive error or runt frame
        logic bad_fcs;
    } rx_status_t;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_wait_last
    } rx_state_e;

    localparam gmii_byte_t eth_preamble = 8'h55;
    localparam gmii_byte_t eth_sfd      = 8'hD5;

    // Reflected IEEE 802.3 polynomial, the register shifts toward bit 0
    localparam crc_t crc_poly = 32'hEDB88320;
    localparam crc_t crc_init = 32'hFFFFFFFF;

    // Register value after a good frame plus its FCS, taken before any final inversion
    localparam crc_t crc_residue = 32'hDEBB20E3;

    // The FCS is held back in the history, one more stage marks the end of the frame
    localparam int fcs_len     = 4;
    localparam int delay_depth = fcs_len + 1;

endpackage

//--- src/gmii_rx_delay_line.sv
// Five-stage GMII sample history; stage 0 is one cycle behind the pins, data bytes have no reset
`timescale 1ns/1ps

module gmii_rx_delay_line (
    input  logic                                                     rx_clk,
    input  logic                                                     rx_rst,
    input  gmii_rx_pkg::gmii_sample_t                                sample,
    output gmii_rx_pkg::gmii_sample_t [gmii_rx_pkg::delay_depth-1:0] hist
);

    import gmii_rx_pkg::*;

    logic [delay_depth-1:0] dv_q;        // Bit 0 is the newest sample
    logic [delay_depth-1:0] er_q;
    gmii_byte_t             data_q [delay_depth];

    // Clearing dv and er keeps a stale byte from looking like a frame after reset
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            dv_q <= '0;
            er_q <= '0;
        end else begin
            dv_q <= {dv_q[delay_depth-2:0], sample.dv};
            er_q <= {er_q[delay_depth-2:0], sample.er};
        end
    end

    always_ff @(posedge rx_clk) begin
        data_q[0] <= sample.data;
        for (int i = 1; i < delay_depth; i++) begin
            data_q[i] <= data_q[i-1];    // Shift toward the oldest stage
        end
    end

    always_comb begin
        for (int i = 0; i < delay_depth; i++) begin
            hist[i] = '{data: data_q[i], dv: dv_q[i], er: er_q[i]};
        end
    end

endmodule

//--- src/eth_crc32.sv
// Byte-serial reflected CRC-32 over the frame and its FCS; crc_ok is meaningful only after the FCS
`timescale 1ns/1ps

module eth_crc32 (
    input  logic                   rx_clk,
    input  logic                   rx_rst,
    input  gmii_rx_pkg::gmii_byte_t data,
    input  logic                   crc_clear,
    input  logic                   crc_update,
    output logic                   crc_ok
);

    import gmii_rx_pkg::*;

    crc_t crc_q;

    // One octet, least significant bit first as it arrives on the wire
    function automatic crc_t crc_next(crc_t crc, gmii_byte_t d);
        crc_t c;
        c = crc ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_q <= crc_init;
        end else if (crc_clear) begin
            crc_q <= crc_init;           // Clear wins over an update in the same cycle
        end else if (crc_update) begin
            crc_q <= crc_next(crc_q, data);
        end
    end

    // Running the FCS through the register leaves the fixed residue on a good frame
    assign crc_ok = (crc_q == crc_residue);

endmodule

//--- src/gmii_rx_frame_ctrl.sv
// GMII receive framing FSM; no back-pressure, beats are strobes and frames need a 6-cycle idle gap
`timescale 1ns/1ps

module gmii_rx_frame_ctrl (
    input  logic                                                     rx_clk,
    input  logic                                                     rx_rst,
    input  gmii_rx_pkg::gmii_sample_t [gmii_rx_pkg::delay_depth-1:0] hist,
    input  logic                                                     cfg_rx_enable,
    input  logic                                                     crc_ok,
    output logic                                                     crc_clear,
    output logic                                                     crc_update,
    output gmii_rx_pkg::rx_beat_t                                    m_beat,
    output logic                                                     m_valid,
    output gmii_rx_pkg::rx_status_t                                  status
);

    import gmii_rx_pkg::*;

    rx_state_e  state_q;
    rx_state_e  state_d;

    logic [2:0] fill_q;                  // Bytes of the frame that have entered the history
    logic       err_q;                   // An er cycle was seen inside the frame
    logic       pend_valid_q;            // A payload byte waits for the next one or the end
    gmii_byte_t pend_q;

    gmii_byte_t beat_data_q;
    logic       beat_last_q;
    logic       beat_user_q;

    logic       sof;
    logic       start;
    logic       load_pend;
    logic       frame_end;
    logic       frame_bad;

    // SFD in the newest stage right behind a preamble octet
    assign sof = hist[0].dv && (hist[0].data == eth_sfd) &&
                 hist[1].dv && (hist[1].data == eth_preamble);

    assign start = (state_q == st_idle) && sof && cfg_rx_enable;

    assign crc_clear  = start;
    assign crc_update = (state_q == st_payload) && hist[0].dv;

    // The oldest stage carries payload only once the first byte has travelled through
    assign load_pend = crc_update && (fill_q == 3'(fcs_len));

    // Stages 1 to 4 now hold the FCS, so the byte in pend_q is the final payload byte
    assign frame_end = (state_q == st_payload) && !hist[0].dv;

    assign frame_bad = err_q || !pend_valid_q;  // A runt frame has no payload at all

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (sof) begin
                    state_d = cfg_rx_enable ? st_payload : st_wait_last;  // Drop when disabled
                end
            end
            st_payload: begin
                if (!hist[0].dv) begin
                    state_d = st_wait_last;
                end
            end
            st_wait_last: begin
                if (!hist[0].dv) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state_q      <= st_idle;
            fill_q       <= '0;
            err_q        <= 1'b0;
            pend_valid_q <= 1'b0;
            m_valid      <= 1'b0;
            beat_last_q  <= 1'b0;
            beat_user_q  <= 1'b0;
            status       <= '0;
        end else begin
            state_q     <= state_d;
            m_valid     <= 1'b0;
            beat_last_q <= 1'b0;
            beat_user_q <= 1'b0;
            status      <= '0;

            if (start) begin
                fill_q              <= '0;
                err_q               <= 1'b0;
                pend_valid_q        <= 1'b0;
                status.start_packet <= 1'b1;
            end

            if (crc_update) begin
                if (fill_q != 3'(fcs_len)) begin
                    fill_q <= fill_q + 3'd1;
                end
                if (hist[0].er) begin
                    err_q <= 1'b1;
                end
            end

            // The held byte goes out as soon as a newer payload byte replaces it
            if (load_pend) begin
                m_valid      <= pend_valid_q;
                pend_valid_q <= 1'b1;
            end

            if (frame_end) begin
                m_valid          <= pend_valid_q;
                beat_last_q      <= 1'b1;
                beat_user_q      <= pend_valid_q && (err_q || !crc_ok);
                status.bad_frame <= frame_bad;
                status.bad_fcs   <= !frame_bad && !crc_ok;  // Receive errors take priority
                pend_valid_q     <= 1'b0;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (load_pend || frame_end) begin
            beat_data_q <= pend_q;
        end
        if (load_pend) begin
            pend_q <= hist[delay_depth-1].data;
        end
    end

    assign m_beat = '{data: beat_data_q, last: beat_last_q, user: beat_user_q};

endmodule

//--- src/gmii_rx_mac.sv
// 1G GMII receive MAC on rx_clk only; no ready on the output stream, FCS is stripped and checked
`timescale 1ns/1ps

module gmii_rx_mac (
    input  logic                    rx_clk,
    input  logic                    rx_rst,
    input  gmii_rx_pkg::gmii_byte_t gmii_rxd,
    input  logic                    gmii_rx_dv,
    input  logic                    gmii_rx_er,
    input  logic                    cfg_rx_enable,
    output gmii_rx_pkg::gmii_byte_t rx_axis_tdata,
    output logic                    rx_axis_tvalid,
    output logic                    rx_axis_tlast,
    output logic                    rx_axis_tuser,
    output logic                    rx_start_packet,
    output logic                    rx_error_bad_frame,
    output logic                    rx_error_bad_fcs
);

    import gmii_rx_pkg::*;

    gmii_sample_t                    pins;
    gmii_sample_t [delay_depth-1:0]  hist;
    logic                            crc_clear;
    logic                            crc_update;
    logic                            crc_ok;
    rx_beat_t                        beat;
    rx_status_t                      status;

    assign pins = '{data: gmii_rxd, dv: gmii_rx_dv, er: gmii_rx_er};

    gmii_rx_delay_line u_delay_line (
        .rx_clk (rx_clk),
        .rx_rst (rx_rst),
        .sample (pins),
        .hist   (hist)
    );

    eth_crc32 u_crc (
        .rx_clk     (rx_clk),
        .rx_rst     (rx_rst),
        .data       (hist[0].data),      // The CRC sees each byte as it enters the history
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_ok     (crc_ok)
    );

    gmii_rx_frame_ctrl u_frame_ctrl (
        .rx_clk        (rx_clk),
        .rx_rst        (rx_rst),
        .hist          (hist),
        .cfg_rx_enable (cfg_rx_enable),
        .crc_ok        (crc_ok),
        .crc_clear     (crc_clear),
        .crc_update    (crc_update),
        .m_beat        (beat),
        .m_valid       (rx_axis_tvalid),
        .status        (status)
    );

    assign rx_axis_tdata      = beat.data;
    assign rx_axis_tlast      = beat.last;
    assign rx_axis_tuser      = beat.user;
    assign rx_start_packet    = status.start_packet;
    assign rx_error_bad_frame = status.bad_frame;
    assign rx_error_bad_fcs   = status.bad_fcs;

endmodule

//--- verification/gmii_rx_chk.sv
// Output assertions bound into gmii_rx_mac; pulse and flag checks are off while rx_rst is high
`timescale 1ns/1ps

module gmii_rx_chk (
    input logic                  rx_clk,
    input logic                  rx_rst,
    input logic                  rx_axis_tvalid,
    input logic                  rx_axis_tlast,
    input logic                  rx_axis_tuser,
    input logic                  rx_start_packet,
    input logic                  rx_error_bad_frame,
    input logic                  rx_error_bad_fcs,
    input gmii_rx_pkg::rx_state_e state
);

    import gmii_rx_pkg::*;

    int unsigned fail_count = 0;         // Number of failed assertions so far

    // Outputs and the FSM sit idle one edge into reset
    reset_idle: assert property (@(posedge rx_clk) rx_rst |=>
        (!rx_axis_tvalid && !rx_axis_tlast && !rx_axis_tuser && !rx_start_packet &&
         !rx_error_bad_frame && !rx_error_bad_fcs && state == st_idle))
        else begin
            fail_count++;
            $error("Outputs or state not idle during reset");
        end

    start_one_cycle: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_start_packet |=> !rx_start_packet)
        else begin
            fail_count++;
            $error("rx_start_packet high for more than one cycle");
        end

    bad_frame_one_cycle: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_error_bad_frame |=> !rx_error_bad_frame)
        else begin
            fail_count++;
            $error("rx_error_bad_frame high for more than one cycle");
        end

    bad_fcs_one_cycle: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_error_bad_fcs |=> !rx_error_bad_fcs)
        else begin
            fail_count++;
            $error("rx_error_bad_fcs high for more than one cycle");
        end

    user_on_last_beat: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_axis_tuser |-> rx_axis_tvalid && rx_axis_tlast)
        else begin
            fail_count++;
            $error("rx_axis_tuser set outside a valid last beat");
        end

    // A bad FCS always comes with a payload beat marked bad
    fcs_marks_user: assert property (@(posedge rx_clk) disable iff (rx_rst)
        rx_error_bad_fcs |-> rx_axis_tvalid && rx_axis_tlast && rx_axis_tuser)
        else begin
            fail_count++;
            $error("rx_error_bad_fcs without a flagged last beat");
        end

    errors_exclusive: assert property (@(posedge rx_clk) disable iff (rx_rst)
        !(rx_error_bad_fcs && rx_error_bad_frame))
        else begin
            fail_count++;
            $error("rx_error_bad_fcs and rx_error_bad_frame on the same cycle");
        end

endmodule

bind gmii_rx_mac gmii_rx_chk u_chk (
    .rx_clk             (rx_clk),
    .rx_rst             (rx_rst),
    .rx_axis_tvalid     (rx_axis_tvalid),
    .rx_axis_tlast      (rx_axis_tlast),
    .rx_axis_tuser      (rx_axis_tuser),
    .rx_start_packet    (rx_start_packet),
    .rx_error_bad_frame (rx_error_bad_frame),
    .rx_error_bad_fcs   (rx_error_bad_fcs),
    .state              (u_frame_ctrl.state_q)
);

//--- verification/gmii_rx_tb.sv
// Needs verification/gmii_rx_trace.txt relative to the run directory; idle gaps are 12 to 27 cycles
`timescale 1ns/1ps

module gmii_rx_tb;

    import gmii_rx_pkg::*;

    localparam int trace_words  = 1024;
    localparam int last_timeout = 5;     // Cycles allowed for the final beat once dv drops

    logic       rx_clk;
    logic       rx_rst;
    gmii_byte_t gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic       cfg_rx_enable;
    gmii_byte_t rx_axis_tdata;
    logic       rx_axis_tvalid;
    logic       rx_axis_tlast;
    logic       rx_axis_tuser;
    logic       rx_start_packet;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;

    logic [7:0] trace_mem [trace_words];
    int         ptr;
    logic [7:0] lfsr_state;

    rx_beat_t   beat_q [$];              // Beats seen by the monitor for the current record
    int         start_count;
    int         fcs_count;
    int         frame_count;
    logic       last_seen;
    logic       last_bad_fcs;
    logic       last_bad_frame;

    logic       rec_enable;
    logic [7:0] rec_er_idx;              // Payload index of the er cycle, FF for none
    logic       rec_user;
    logic       rec_bad_fcs;
    logic       rec_bad_frame;
    gmii_byte_t wire_q [$];
    gmii_byte_t pay_q [$];

    gmii_rx_mac dut (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .cfg_rx_enable      (cfg_rx_enable),
        .rx_axis_tdata      (rx_axis_tdata),
        .rx_axis_tvalid     (rx_axis_tvalid),
        .rx_axis_tlast      (rx_axis_tlast),
        .rx_axis_tuser      (rx_axis_tuser),
        .rx_start_packet    (rx_start_packet),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

    initial begin
        rx_clk = 1'b0;
        forever #4 rx_clk = ~rx_clk;     // 125 MHz GMII receive clock
    end

    // Polynomial x^8 + x^6 + x^5 + x^4 + 1, new bit enters at bit 0
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0d ns: %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    task automatic take_word(output logic [7:0] w);
        if (ptr >= trace_words || $isunknown(trace_mem[ptr])) begin
            fail_run($sformatf("Trace file is missing or ends early at word %0d", ptr));
        end
        w = trace_mem[ptr];
        ptr++;
    endtask

    task automatic read_record(output logic found);
        logic [7:0] w;
        logic [7:0] n;
        take_word(w);
        if (w != 8'hA5 && w != 8'h00) begin
            fail_run($sformatf("Trace word %0d is not a record marker", ptr - 1));
        end
        found = (w == 8'hA5);
        if (found) begin
            take_word(w);
            rec_enable = w[0];
            take_word(rec_er_idx);
            take_word(w);
            rec_user = w[0];
            take_word(w);
            rec_bad_fcs = w[0];
            take_word(w);
            rec_bad_frame = w[0];
            take_word(n);
            wire_q.delete();
            for (int i = 0; i < n; i++) begin
                take_word(w);
                wire_q.push_back(w);
            end
            take_word(n);
            pay_q.delete();
            for (int i = 0; i < n; i++) begin
                take_word(w);
                pay_q.push_back(w);
            end
        end
    endtask

    task automatic clear_monitor();
        beat_q.delete();
        start_count    = 0;
        fcs_count      = 0;
        frame_count    = 0;
        last_seen      = 1'b0;
        last_bad_fcs   = 1'b0;
        last_bad_frame = 1'b0;
    endtask

    task automatic send_frame();
        for (int i = 0; i < wire_q.size(); i++) begin
            @(posedge rx_clk);
            gmii_rxd   <= wire_q[i];
            gmii_rx_dv <= 1'b1;
            gmii_rx_er <= (rec_er_idx != 8'hFF) && (i == int'(rec_er_idx) + 8);  // After SFD
        end
        @(posedge rx_clk);
        gmii_rxd   <= '0;
        gmii_rx_dv <= 1'b0;
        gmii_rx_er <= 1'b0;
    endtask

    task automatic wait_last_beat();
        int cycles;
        cycles = 0;
        while (!last_seen && cycles < last_timeout) begin
            @(posedge rx_clk);
            cycles++;
        end
        if (!last_seen) begin
            fail_run($sformatf("No final beat within %0d cycles after dv dropped", last_timeout));
        end
    endtask

    task automatic idle_gap();
        logic [3:0] bits;
        bits = '0;
        for (int b = 0; b < 4; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[2:0], lfsr_state[0]};
        end
        repeat (12 + int'(bits)) @(posedge rx_clk);
    endtask

    task automatic check_record();
        int n;
        n = pay_q.size();
        compare_value("beat count", beat_q.size(), n);
        for (int i = 0; i < n; i++) begin
            compare_value($sformatf("rx_axis_tdata[%0d]", i), beat_q[i].data, pay_q[i]);
            compare_value($sformatf("rx_axis_tlast[%0d]", i), beat_q[i].last, i == n - 1);
            compare_value($sformatf("rx_axis_tuser[%0d]", i), beat_q[i].user,
                          (i == n - 1) ? rec_user : 1'b0);
        end
        compare_value("rx_start_packet pulses", start_count, rec_enable);
        compare_value("rx_error_bad_fcs pulses", fcs_count, rec_bad_fcs);
        compare_value("rx_error_bad_frame pulses", frame_count, rec_bad_frame);
        if (n > 0) begin
            compare_value("rx_error_bad_fcs on last beat", last_bad_fcs, rec_bad_fcs);
            compare_value("rx_error_bad_frame on last beat", last_bad_frame, rec_bad_frame);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge rx_clk) begin
        rx_beat_t beat;
        if (!rx_rst) begin
            if (rx_axis_tvalid) begin
                beat = '{data: rx_axis_tdata, last: rx_axis_tlast, user: rx_axis_tuser};
                beat_q.push_back(beat);
                if (rx_axis_tlast) begin
                    last_seen      = 1'b1;
                    last_bad_fcs   = rx_error_bad_fcs;
                    last_bad_frame = rx_error_bad_frame;
                end
            end
            start_count += rx_start_packet;
            fcs_count   += rx_error_bad_fcs;
            frame_count += rx_error_bad_frame;
        end
    end

    // Failed assertions of the bound checker
    always @(dut.u_chk.fail_count) begin
        if (dut.u_chk.fail_count != 0) begin
            fail_run("An assertion in the bound gmii_rx_chk checker failed");
        end
    end

    initial begin
        logic found;
        int   rec_count;
        rx_rst        = 1'b1;
        gmii_rxd      = '0;
        gmii_rx_dv    = 1'b0;
        gmii_rx_er    = 1'b0;
        cfg_rx_enable = 1'b0;
        ptr           = 0;
        rec_count     = 0;
        lfsr_state    = 8'd86;
        clear_monitor();
        $readmemh("verification/gmii_rx_trace.txt", trace_mem);
        repeat (5) @(posedge rx_clk);
        rx_rst <= 1'b0;
        repeat (4) @(posedge rx_clk);
        read_record(found);
        while (found) begin
            @(posedge rx_clk);
            cfg_rx_enable <= rec_enable;     // Settled long before the SFD arrives
            send_frame();
            if (pay_q.size() > 0) begin
                wait_last_beat();
            end
            idle_gap();
            check_record();
            clear_monitor();
            rec_count++;
            read_record(found);
        end
        if (rec_count == 0) begin
            fail_run("Trace file holds no frame records");
        end
        if (dut.u_chk.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verification/gmii_rx_trace.txt
// Record: A5, enable, er payload index (FF none), user, bad_fcs, bad_frame, wire length,
// wire bytes (preamble, SFD, payload, FCS), payload length, payload bytes; 00 ends the file
// Good frame "123456789"
A5 01 FF 00 00 00
15 55 55 55 55 55 55 55 D5 31 32 33 34 35 36 37 38 39 26 39 F4 CB
09 31 32 33 34 35 36 37 38 39
// "abc" with bit 0 of the first FCS octet flipped
A5 01 FF 01 01 00
0F 55 55 55 55 55 55 55 D5 61 62 63 C3 41 24 35
03 61 62 63
// "hello world" with er on payload byte 4
A5 01 04 01 00 01
17 55 55 55 55 55 55 55 D5 68 65 6C 6C 6F 20 77 6F 72 6C 64 85 11 4A 0D
0B 68 65 6C 6C 6F 20 77 6F 72 6C 64
// "a" while the receiver is disabled
A5 00 FF 00 00 00
0D 55 55 55 55 55 55 55 D5 61 43 BE B7 E8
00
// Good 43-byte frame right after the disabled one
A5 01 FF 00 00 00
37 55 55 55 55 55 55 55 D5
54 68 65 20 71 75 69 63 6B 20 62 72 6F 77 6E 20 66 6F 78 20 6A 75
6D 70 73 20 6F 76 65 72 20 74 68 65 20 6C 61 7A 79 20 64 6F 67
39 A3 4F 41
2B
54 68 65 20 71 75 69 63 6B 20 62 72 6F 77 6E 20 66 6F 78 20 6A 75
6D 70 73 20 6F 76 65 72 20 74 68 65 20 6C 61 7A 79 20 64 6F 67
// Good one-byte payload "a"
A5 01 FF 00 00 00
0D 55 55 55 55 55 55 55 D5 61 43 BE B7 E8
01 61
// "123456789" with er on the last payload byte
A5 01 08 01 00 01
15 55 55 55 55 55 55 55 D5 31 32 33 34 35 36 37 38 39 26 39 F4 CB
09 31 32 33 34 35 36 37 38 39
// Good frame "abc"
A5 01 FF 00 00 00
0F 55 55 55 55 55 55 55 D5 61 62 63 C2 41 24 35
03 61 62 63
00

//--- compile.f
src/gmii_rx_pkg.sv
src/gmii_rx_delay_line.sv
src/eth_crc32.sv
src/gmii_rx_frame_ctrl.sv
src/gmii_rx_mac.sv
verification/gmii_rx_chk.sv
verification/gmii_rx_tb.sv

//--- Bender.yml
package:
  name: gmii_rx_mac

sources:
  # RTL, package first
  - src/gmii_rx_pkg.sv
  - src/gmii_rx_delay_line.sv
  - src/eth_crc32.sv
  - src/gmii_rx_frame_ctrl.sv
  - src/gmii_rx_mac.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/gmii_rx_chk.sv
      - verification/gmii_rx_tb.sv
